// File: hdl/sru_pkg.sv
package sru_pkg;

    // --------------------------------------------------
    // front-end card and link counts
    // --------------------------------------------------
    localparam int NUM_FEE      = 40;
    localparam int FEE_PER_LINK = 20;
    localparam int NUM_LINKS    = 2;
    // mask bits above the low register word
    localparam int MASK_HI_BITS = NUM_FEE - 32;

    // one bit per front-end card
    typedef logic [NUM_FEE-1:0] fee_mask_t;

    // --------------------------------------------------
    // register map, byte addresses
    // --------------------------------------------------
    localparam logic [7:0] REG_FW_VERSION  = 8'h00;
    localparam logic [7:0] REG_SRU_CFG     = 8'h04;
    localparam logic [7:0] REG_RDO_MASK_LO = 8'h08;
    localparam logic [7:0] REG_RDO_MASK_HI = 8'h0C;
    localparam logic [7:0] REG_STATUS      = 8'h10;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // configuration word, msb first
    typedef struct packed {
        logic       spare_31;
        logic       rdocmd_opt;
        logic [5:0] spare_29_24;
        logic [7:0] par_req;
        logic [7:0] spare_15_8;
        logic [1:0] busy_in_en;
        logic [1:0] trig_mode;
        logic [2:0] spare_3_1;
        logic       rdo_clk_sel;
    } sru_cfg_t;

    // raw status inputs from the board
    typedef struct packed {
        logic [1:0] busy_in;
        logic       trig_busy;
        logic       ttc_ready;
        logic       eth_sync;
        logic       dcs_lock;
        logic       ser_lock;
        logic [3:0] rorc_status;
        logic [5:0] trigerr;
    } link_status_t;

    // status word as seen at REG_STATUS
    typedef struct packed {
        logic       rsvd_31;
        logic       trig_busy;
        logic [7:0] rsvd_29_22;
        logic       fee_err_or;
        logic [2:0] rsvd_20_18;
        logic [5:0] trigerr;
        logic [1:0] rsvd_11_10;
        logic [3:0] rorc_status;
        logic       ser_lock;
        logic       dcs_lock;
        logic       eth_sync;
        logic       ttc_ready;
        logic       rsvd_1;
        logic       busy;
    } sru_status_t;

    // --------------------------------------------------
    // AXI4-Lite channels
    // --------------------------------------------------
    typedef struct packed {
        logic [7:0]  awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [7:0]  araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axil_rsp_t;

endpackage

// File: hdl/sync_stage.sv
module sync_stage #(
    parameter type T = logic
) (
    input  logic rdoclk,
    input  logic rst_i,
    input  T     d_i,
    output T     q_o
);

    // first flop may go metastable
    T meta_q;

    always_ff @(posedge rdoclk) begin
        if (rst_i) begin
            meta_q <= '0;
            q_o    <= '0;
        end else begin
            meta_q <= d_i;
            q_o    <= meta_q;
        end
    end

endmodule

// File: hdl/sru_reg_bank.sv
module sru_reg_bank #(
    parameter logic [31:0] FW_VERSION = 32'h16091512
) (
    input  logic                  rdoclk,
    input  logic                  rst_i,
    input  sru_pkg::axil_req_t    bus_req_i,
    output sru_pkg::axil_rsp_t    bus_rsp_o,
    input  sru_pkg::sru_status_t  status_i,
    output sru_pkg::sru_cfg_t     cfg_o,
    output sru_pkg::fee_mask_t    rdo_mask_o
);

    import sru_pkg::*;

    // byte-wise merge of a write into a stored word
    function automatic logic [31:0] merge_bytes(
        input logic [31:0] old_val,
        input logic [31:0] new_val,
        input logic [3:0]  strb
    );
        logic [31:0] res;
        res = old_val;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return res;
    endfunction

    sru_cfg_t                cfg_q;
    logic [31:0]             mask_lo_q;
    logic [MASK_HI_BITS-1:0] mask_hi_q;

    logic        wr_go;
    logic        wr_legal;
    logic        wr_rdy_q;
    logic        bvalid_q;
    logic [1:0]  bresp_q;

    logic        rd_go;
    logic        ar_rdy_q;
    logic        rvalid_q;
    logic [31:0] rdata_q;
    logic [1:0]  rresp_q;
    logic [31:0] rd_data;
    logic [1:0]  rd_resp;

    // --------------------------------------------------
    // write channel
    // --------------------------------------------------
    // accept only when idle and no response is waiting
    assign wr_go = bus_req_i.awvalid && bus_req_i.wvalid && !wr_rdy_q && !bvalid_q;

    assign wr_legal = (bus_req_i.awaddr == REG_SRU_CFG) ||
                      (bus_req_i.awaddr == REG_RDO_MASK_LO) ||
                      (bus_req_i.awaddr == REG_RDO_MASK_HI);

    always_ff @(posedge rdoclk) begin
        if (rst_i) begin
            wr_rdy_q  <= 1'b0;
            bvalid_q  <= 1'b0;
            cfg_q     <= '0;
            mask_lo_q <= '0;
            mask_hi_q <= '0;
        end else begin
            wr_rdy_q <= wr_go;
            if (wr_rdy_q) begin
                bvalid_q <= 1'b1;
            end else if (bvalid_q && bus_req_i.bready) begin
                bvalid_q <= 1'b0;
            end
            if (wr_go) begin
                case (bus_req_i.awaddr)
                    REG_SRU_CFG: begin
                        cfg_q <= merge_bytes(cfg_q, bus_req_i.wdata, bus_req_i.wstrb);
                    end
                    REG_RDO_MASK_LO: begin
                        mask_lo_q <= merge_bytes(mask_lo_q, bus_req_i.wdata,
                                                 bus_req_i.wstrb);
                    end
                    REG_RDO_MASK_HI: begin
                        // only the low byte is backed by flops
                        if (bus_req_i.wstrb[0]) begin
                            mask_hi_q <= bus_req_i.wdata[MASK_HI_BITS-1:0];
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge rdoclk) begin
        if (wr_go) begin
            bresp_q <= wr_legal ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // --------------------------------------------------
    // read channel
    // --------------------------------------------------
    assign rd_go = bus_req_i.arvalid && !ar_rdy_q && !rvalid_q;

    always_comb begin
        rd_data = '0;
        rd_resp = RESP_OKAY;
        case (bus_req_i.araddr)
            REG_FW_VERSION:  rd_data = FW_VERSION;
            REG_SRU_CFG:     rd_data = cfg_q;
            REG_RDO_MASK_LO: rd_data = mask_lo_q;
            REG_RDO_MASK_HI: rd_data = {{(32-MASK_HI_BITS){1'b0}}, mask_hi_q};
            REG_STATUS:      rd_data = status_i;
            default:         rd_resp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge rdoclk) begin
        if (rst_i) begin
            ar_rdy_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            ar_rdy_q <= rd_go;
            if (ar_rdy_q) begin
                rvalid_q <= 1'b1;
            end else if (rvalid_q && bus_req_i.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // data held stable while rvalid waits
    always_ff @(posedge rdoclk) begin
        if (ar_rdy_q) begin
            rdata_q <= rd_data;
            rresp_q <= rd_resp;
        end
    end

    always_comb begin
        bus_rsp_o.awready = wr_rdy_q;
        bus_rsp_o.wready  = wr_rdy_q;
        bus_rsp_o.bresp   = bresp_q;
        bus_rsp_o.bvalid  = bvalid_q;
        bus_rsp_o.arready = ar_rdy_q;
        bus_rsp_o.rdata   = rdata_q;
        bus_rsp_o.rresp   = rresp_q;
        bus_rsp_o.rvalid  = rvalid_q;
    end

    assign cfg_o      = cfg_q;
    assign rdo_mask_o = {mask_hi_q, mask_lo_q};

endmodule

// File: hdl/sru_status_unit.sv
module sru_status_unit (
    input  logic                           rdoclk,
    input  logic                           rst_i,
    input  sru_pkg::link_status_t          link_i,
    input  sru_pkg::fee_mask_t             err_flag_i,
    input  sru_pkg::sru_cfg_t              cfg_i,
    input  sru_pkg::fee_mask_t             rdo_mask_i,
    output logic                           busy_o,
    output logic [sru_pkg::NUM_LINKS-1:0]  ddl_xoff_o,
    output sru_pkg::sru_status_t           status_o
);

    import sru_pkg::*;

    logic                 busy_d;
    logic [NUM_LINKS-1:0] xoff_d;
    logic                 fee_err_d;
    sru_status_t          status_d;

    // --------------------------------------------------
    // busy merge and link flow control
    // --------------------------------------------------
    // external busy lines only count when enabled
    assign busy_d = (|(link_i.busy_in & cfg_i.busy_in_en)) | link_i.trig_busy;

    // a link is throttled once every card on it is masked out
    always_comb begin
        for (int k = 0; k < NUM_LINKS; k++) begin
            xoff_d[k] = &rdo_mask_i[k*FEE_PER_LINK +: FEE_PER_LINK];
        end
    end

    // masked cards never raise the error summary
    assign fee_err_d = |(err_flag_i & ~rdo_mask_i);

    // --------------------------------------------------
    // status word
    // --------------------------------------------------
    always_comb begin
        status_d             = '0;
        status_d.busy        = busy_d;
        status_d.ttc_ready   = link_i.ttc_ready;
        status_d.eth_sync    = link_i.eth_sync;
        status_d.dcs_lock    = link_i.dcs_lock;
        status_d.ser_lock    = link_i.ser_lock;
        status_d.rorc_status = link_i.rorc_status;
        status_d.trigerr     = link_i.trigerr;
        status_d.fee_err_or  = fee_err_d;
        status_d.trig_busy   = link_i.trig_busy;
    end

    always_ff @(posedge rdoclk) begin
        if (rst_i) begin
            busy_o     <= 1'b0;
            ddl_xoff_o <= '0;
            status_o   <= '0;
        end else begin
            busy_o     <= busy_d;
            ddl_xoff_o <= xoff_d;
            status_o   <= status_d;
        end
    end

endmodule

// File: hdl/led_blinker.sv
module led_blinker #(
    parameter int BLINK_BITS = 25
) (
    input  logic       rdoclk,
    input  logic       rst_i,
    input  logic       busy_i,
    input  logic       ttc_ready_i,
    input  logic       eth_sync_i,
    input  logic       locks_ok_i,
    output logic [3:0] led_o
);

    // free-running divider
    logic [BLINK_BITS-1:0] div_q;
    logic                  slow_tick;
    logic                  fast_tick;

    assign slow_tick = div_q[BLINK_BITS-1];
    assign fast_tick = div_q[BLINK_BITS-2];

    always_ff @(posedge rdoclk) begin
        if (rst_i) begin
            div_q <= '0;
            led_o <= '0;
        end else begin
            div_q    <= div_q + 1'b1;
            // busy blinks at half the rate of the others
            led_o[0] <= busy_i & slow_tick;
            led_o[1] <= ttc_ready_i & fast_tick;
            led_o[2] <= eth_sync_i & fast_tick;
            led_o[3] <= locks_ok_i & fast_tick;
        end
    end

endmodule

// File: hdl/sru_ctrl_top.sv
module sru_ctrl_top #(
    parameter logic [31:0] FW_VERSION = 32'h16091512,
    parameter int          BLINK_BITS = 25
) (
    input  logic                           rdoclk,
    input  logic                           rst_i,
    input  sru_pkg::axil_req_t             bus_req_i,
    output sru_pkg::axil_rsp_t             bus_rsp_o,
    input  sru_pkg::link_status_t          link_status_i,
    input  sru_pkg::fee_mask_t             dtc_err_flag_i,
    output logic                           busy_o,
    output logic [sru_pkg::NUM_LINKS-1:0]  ddl_xoff_o,
    output logic [3:0]                     led_o
);

    import sru_pkg::*;

    link_status_t link_sync;
    fee_mask_t    err_sync;
    sru_cfg_t     cfg;
    fee_mask_t    rdo_mask;
    sru_status_t  status;
    logic         locks_ok;

    // --------------------------------------------------
    // input synchronizers
    // --------------------------------------------------
    sync_stage #(.T(link_status_t)) u_link_sync (
        .rdoclk (rdoclk),
        .rst_i  (rst_i),
        .d_i    (link_status_i),
        .q_o    (link_sync)
    );

    sync_stage #(.T(fee_mask_t)) u_err_sync (
        .rdoclk (rdoclk),
        .rst_i  (rst_i),
        .d_i    (dtc_err_flag_i),
        .q_o    (err_sync)
    );

    // --------------------------------------------------
    // registers, status and leds
    // --------------------------------------------------
    sru_reg_bank #(.FW_VERSION(FW_VERSION)) u_reg_bank (
        .rdoclk     (rdoclk),
        .rst_i      (rst_i),
        .bus_req_i  (bus_req_i),
        .bus_rsp_o  (bus_rsp_o),
        .status_i   (status),
        .cfg_o      (cfg),
        .rdo_mask_o (rdo_mask)
    );

    sru_status_unit u_status_unit (
        .rdoclk     (rdoclk),
        .rst_i      (rst_i),
        .link_i     (link_sync),
        .err_flag_i (err_sync),
        .cfg_i      (cfg),
        .rdo_mask_i (rdo_mask),
        .busy_o     (busy_o),
        .ddl_xoff_o (ddl_xoff_o),
        .status_o   (status)
    );

    // both clock domains locked
    assign locks_ok = status.dcs_lock & status.ser_lock;

    led_blinker #(.BLINK_BITS(BLINK_BITS)) u_led_blinker (
        .rdoclk      (rdoclk),
        .rst_i       (rst_i),
        .busy_i      (status.busy),
        .ttc_ready_i (status.ttc_ready),
        .eth_sync_i  (status.eth_sync),
        .locks_ok_i  (locks_ok),
        .led_o       (led_o)
    );

endmodule

// File: verification/tb_sru_ctrl.sv
module tb_sru_ctrl;

    import sru_pkg::*;

    localparam logic [31:0] FW_VER     = 32'h16091512;
    localparam int          BLINK_BITS = 6;
    localparam int          HS_LIMIT   = 20;

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_STAT} op_e;

    // one table row whose inputs are applied when the row starts
    typedef struct {
        op_e          op;
        logic [7:0]   addr;
        logic [31:0]  data;
        logic [3:0]   strb;
        link_status_t link;
        fee_mask_t    err;
        logic [31:0]  exp_data;
        logic [1:0]   exp_resp;
        logic [2:0]   exp_pins;
    } entry_t;

    logic         rdoclk;
    logic         rst_i;
    axil_req_t    req;
    axil_rsp_t    rsp;
    link_status_t link_in;
    fee_mask_t    err_in;
    logic         busy;
    logic [1:0]   xoff;
    logic [3:0]   led;

    entry_t       tbl[$];
    logic [31:0]  rng_state;
    // register model
    logic [31:0]  cfg_m;
    logic [31:0]  mask_lo_m;
    logic [7:0]   mask_hi_m;
    link_status_t cur_link;
    fee_mask_t    cur_err;
    int           cycles;
    int           cycle_limit;
    int           n_pass;
    int           n_fail;

    sru_ctrl_top #(
        .FW_VERSION (FW_VER),
        .BLINK_BITS (BLINK_BITS)
    ) UUT (
        .rdoclk         (rdoclk),
        .rst_i          (rst_i),
        .bus_req_i      (req),
        .bus_rsp_o      (rsp),
        .link_status_i  (link_in),
        .dtc_err_flag_i (err_in),
        .busy_o         (busy),
        .ddl_xoff_o     (xoff),
        .led_o          (led)
    );

    always #5 rdoclk = ~rdoclk;

    // watchdog
    always @(posedge rdoclk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // byte lanes selected by the write strobe
    function automatic logic [31:0] lane_merge(logic [31:0] old_v, logic [31:0] new_v,
                                               logic [3:0] strb);
        logic [31:0] keep;
        keep = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (new_v & keep) | (old_v & ~keep);
    endfunction

    function automatic logic [31:0] expect_status(link_status_t l, fee_mask_t e);
        logic [31:0] s;
        fee_mask_t   m;
        m        = {mask_hi_m, mask_lo_m};
        s        = '0;
        s[0]     = (l.busy_in[0] & cfg_m[6]) | (l.busy_in[1] & cfg_m[7]) | l.trig_busy;
        s[2]     = l.ttc_ready;
        s[3]     = l.eth_sync;
        s[4]     = l.dcs_lock;
        s[5]     = l.ser_lock;
        s[9:6]   = l.rorc_status;
        s[17:12] = l.trigerr;
        s[21]    = |(e & ~m);
        s[30]    = l.trig_busy;
        return s;
    endfunction

    // {xoff link 1, xoff link 0, busy}
    function automatic logic [2:0] expect_pins(logic [31:0] s);
        fee_mask_t m;
        m = {mask_hi_m, mask_lo_m};
        return {&m[39:20], &m[19:0], s[0]};
    endfunction

    // --------------------------------------------------
    // table construction
    // --------------------------------------------------
    task automatic add_entry(op_e op, logic [7:0] addr, logic [31:0] data, logic [3:0] strb,
                             logic [31:0] exp_data, logic [1:0] exp_resp, logic [2:0] exp_pins);
        entry_t e;
        e.op       = op;
        e.addr     = addr;
        e.data     = data;
        e.strb     = strb;
        e.link     = cur_link;
        e.err      = cur_err;
        e.exp_data = exp_data;
        e.exp_resp = exp_resp;
        e.exp_pins = exp_pins;
        tbl.push_back(e);
    endtask

    task automatic add_write(logic [7:0] addr, logic [31:0] data, logic [3:0] strb);
        logic [1:0] resp;
        resp = RESP_OKAY;
        case (addr)
            REG_SRU_CFG:     cfg_m = lane_merge(cfg_m, data, strb);
            REG_RDO_MASK_LO: mask_lo_m = lane_merge(mask_lo_m, data, strb);
            REG_RDO_MASK_HI: begin
                if (strb[0]) begin
                    mask_hi_m = data[7:0];
                end
            end
            default:         resp = RESP_SLVERR;
        endcase
        add_entry(OP_WR, addr, data, strb, 32'h0, resp, 3'b000);
    endtask

    task automatic add_read(logic [7:0] addr);
        logic [31:0] d;
        logic [1:0]  resp;
        d    = '0;
        resp = RESP_OKAY;
        case (addr)
            REG_FW_VERSION:  d = FW_VER;
            REG_SRU_CFG:     d = cfg_m;
            REG_RDO_MASK_LO: d = mask_lo_m;
            REG_RDO_MASK_HI: d = {24'h0, mask_hi_m};
            REG_STATUS:      d = expect_status(cur_link, cur_err);
            default:         resp = RESP_SLVERR;
        endcase
        add_entry(OP_RD, addr, 32'h0, 4'h0, d, resp, 3'b000);
    endtask

    task automatic add_stat(link_status_t l, fee_mask_t e);
        logic [31:0] s;
        cur_link = l;
        cur_err  = e;
        s        = expect_status(l, e);
        add_entry(OP_STAT, REG_STATUS, 32'h0, 4'h0, s, RESP_OKAY, expect_pins(s));
    endtask

    task automatic build_table();
        logic [7:0]   rw_regs [3];
        logic [31:0]  r;
        logic [31:0]  lo;
        logic [7:0]   hi;
        link_status_t l;
        fee_mask_t    e;
        rw_regs[0] = REG_SRU_CFG;
        rw_regs[1] = REG_RDO_MASK_LO;
        rw_regs[2] = REG_RDO_MASK_HI;
        // reset values
        add_read(REG_FW_VERSION);
        for (int j = 0; j < 3; j++) begin
            add_read(rw_regs[j]);
        end
        add_stat('0, '0);
        // random data, random strobes
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 3; j++) begin
                r = next_rand();
                add_write(rw_regs[j], next_rand(), r[3:0]);
                add_read(rw_regs[j]);
            end
        end
        // illegal accesses change nothing
        add_write(REG_FW_VERSION, next_rand(), 4'hf);
        add_write(REG_STATUS, next_rand(), 4'hf);
        add_write(8'h14, next_rand(), 4'hf);
        for (int j = 0; j < 3; j++) begin
            add_read(rw_regs[j]);
        end
        add_read(8'h14);
        // busy merge over all input combinations
        for (int en = 0; en < 4; en++) begin
            add_write(REG_SRU_CFG, (cfg_m & ~32'h0000_00c0) | (32'(en) << 6), 4'hf);
            for (int k = 0; k < 8; k++) begin
                l           = '0;
                l.busy_in   = k[1:0];
                l.trig_busy = k[2];
                add_stat(l, '0);
            end
        end
        // link 0 masked, link 1 masked, both, then random
        for (int i = 0; i < 4; i++) begin
            case (i)
                0: begin
                    lo = 32'h000f_ffff;
                    hi = 8'h00;
                end
                1: begin
                    lo = 32'hfff0_0000;
                    hi = 8'hff;
                end
                2: begin
                    lo = 32'hffff_ffff;
                    hi = 8'hff;
                end
                default: begin
                    lo = next_rand();
                    r  = next_rand();
                    hi = r[7:0];
                end
            endcase
            add_write(REG_RDO_MASK_LO, lo, 4'hf);
            add_write(REG_RDO_MASK_HI, {24'h0, hi}, 4'h1);
            for (int j = 0; j < 2; j++) begin
                r = next_rand();
                l = r[$bits(link_status_t)-1:0];
                r = next_rand();
                e = {r[7:0], next_rand()};
                add_stat(l, e);
            end
        end
    endtask

    // --------------------------------------------------
    // bus driver
    // --------------------------------------------------
    task automatic bus_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] resp, output bit ok);
        int n;
        req.awaddr  = addr;
        req.awvalid = 1'b1;
        req.wdata   = data;
        req.wstrb   = strb;
        req.wvalid  = 1'b1;
        req.bready  = 1'b1;
        n = 0;
        while (!(rsp.awready && rsp.wready) && n < HS_LIMIT) begin
            @(posedge rdoclk);
            #1;
            n++;
        end
        ok = rsp.awready && rsp.wready;
        @(posedge rdoclk);
        #1;
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        n = 0;
        while (!rsp.bvalid && n < HS_LIMIT) begin
            @(posedge rdoclk);
            #1;
            n++;
        end
        ok   = ok && rsp.bvalid;
        resp = rsp.bresp;
        // response taken on the coming edge
        @(posedge rdoclk);
        #1;
        req.bready = 1'b0;
    endtask

    task automatic bus_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp, output bit ok);
        int n;
        req.araddr  = addr;
        req.arvalid = 1'b1;
        req.rready  = 1'b1;
        n = 0;
        while (!rsp.arready && n < HS_LIMIT) begin
            @(posedge rdoclk);
            #1;
            n++;
        end
        ok = rsp.arready;
        @(posedge rdoclk);
        #1;
        req.arvalid = 1'b0;
        n = 0;
        while (!rsp.rvalid && n < HS_LIMIT) begin
            @(posedge rdoclk);
            #1;
            n++;
        end
        ok   = ok && rsp.rvalid;
        data = rsp.rdata;
        resp = rsp.rresp;
        @(posedge rdoclk);
        #1;
        req.rready = 1'b0;
    endtask

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    task automatic run_entry(int idx, entry_t e);
        logic [31:0] got;
        logic [1:0]  resp;
        bit          ok;
        bit          bad;
        op_e         op;
        op      = e.op;
        got     = '0;
        bad     = 0;
        link_in = e.link;
        err_in  = e.err;
        if (op == OP_WR) begin
            bus_write(e.addr, e.data, e.strb, resp, ok);
        end else if (op == OP_RD) begin
            bus_read(e.addr, got, resp, ok);
        end else begin
            // two sync flops plus the status register
            repeat (4) @(posedge rdoclk);
            #1;
            assert ({xoff, busy} === e.exp_pins) else begin
                $display("mismatch at time %0t: xoff/busy %b, expected %b",
                         $time, {xoff, busy}, e.exp_pins);
                bad = 1;
            end
            bus_read(REG_STATUS, got, resp, ok);
        end
        assert (ok) else begin
            $display("%s at 0x%02h: handshake did not complete within %0d cycles",
                     op.name(), e.addr, HS_LIMIT);
            bad = 1;
        end
        if (ok) begin
            assert (resp === e.exp_resp) else begin
                $display("mismatch at time %0t: response %b at 0x%02h, expected %b",
                         $time, resp, e.addr, e.exp_resp);
                bad = 1;
            end
            if (op != OP_WR) begin
                assert (got === e.exp_data) else begin
                    $display("mismatch at time %0t: read 0x%08h at 0x%02h, expected 0x%08h",
                             $time, got, e.addr, e.exp_data);
                    bad = 1;
                end
            end
        end
        if (bad) n_fail++;
        else n_pass++;
        $display("test %0d %s 0x%02h: %s", idx, op.name(), e.addr, bad ? "error" : "ok");
    endtask

    task automatic check_leds();
        link_status_t l;
        int           on_cnt [4];
        int           exp_cnt [4];
        bit           bad;
        bad         = 0;
        l           = '0;
        l.ttc_ready = 1'b1;
        l.trig_busy = 1'b1;
        l.dcs_lock  = 1'b1;
        l.ser_lock  = 1'b1;
        link_in     = l;
        // half of one divider period for each active led
        exp_cnt[0] = (1 << BLINK_BITS) / 2;
        exp_cnt[1] = (1 << BLINK_BITS) / 2;
        exp_cnt[2] = 0;
        exp_cnt[3] = (1 << BLINK_BITS) / 2;
        repeat (8) @(posedge rdoclk);
        #1;
        for (int i = 0; i < 4; i++) begin
            on_cnt[i] = 0;
        end
        for (int c = 0; c < (1 << BLINK_BITS); c++) begin
            @(posedge rdoclk);
            #1;
            for (int i = 0; i < 4; i++) begin
                if (led[i]) on_cnt[i]++;
            end
        end
        for (int i = 0; i < 4; i++) begin
            assert (on_cnt[i] == exp_cnt[i]) else begin
                $display("mismatch at time %0t: led %0d on for %0d cycles, expected %0d",
                         $time, i, on_cnt[i], exp_cnt[i]);
                bad = 1;
            end
        end
        if (bad) n_fail++;
        else n_pass++;
        $display("test led duty: %s", bad ? "error" : "ok");
    endtask

    initial begin
        rdoclk    = 1'b0;
        rst_i     = 1'b1;
        req       = '0;
        link_in   = '0;
        err_in    = '0;
        rng_state = 32'hd47f;
        cfg_m     = '0;
        mask_lo_m = '0;
        mask_hi_m = '0;
        cur_link  = '0;
        cur_err   = '0;
        cycles    = 0;
        n_pass    = 0;
        n_fail    = 0;
        build_table();
        cycle_limit = 10 + tbl.size() * 20 + 4 * (1 << BLINK_BITS) + 100;
        repeat (10) @(posedge rdoclk);
        #1;
        rst_i = 1'b0;
        foreach (tbl[i]) begin
            run_entry(i, tbl[i]);
        end
        check_leds();
        $display("passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
hdl/sru_pkg.sv
hdl/sync_stage.sv
hdl/sru_reg_bank.sv
hdl/sru_status_unit.sv
hdl/led_blinker.sv
hdl/sru_ctrl_top.sv
verification/tb_sru_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

rm -rf "$BUILD"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sru_ctrl -Mdir "$BUILD" -f project.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD/Vtb_sru_ctrl" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    exit 1
fi

exit 0
